// File: hw/bp_pkg.sv
// Branch predictor shared definitions
package bp_pkg;

    // ----------------------------------------
    // RV32I opcodes seen by the predictor
    // ----------------------------------------
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [1:0] REG_CTRL     = 2'd0; // Bit 0 enable, bit 1 flush
    localparam logic [1:0] REG_BRANCHES = 2'd1; // Resolved conditional branches
    localparam logic [1:0] REG_MISSES   = 2'd2; // Mispredicted conditional branches

    // Weakly not taken
    localparam logic [1:0] PHT_INIT   = 2'b01;
    localparam int         STAT_WIDTH = 16;

    // Fetch-side prediction
    typedef struct packed {
        logic        taken;
        logic [31:0] target; // Zero unless taken
    } bp_predict_t;

    // Resolution coming back from execute
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        logic [6:0]  op;
        logic        taken;      // Resolved direction
        logic        pred_taken; // Direction predicted at fetch
    } bp_update_t;

endpackage

// File: hw/bp_btb.sv
// Branch target buffer
module bp_btb #(
    parameter int NUM_BTB_ENTRIES = 32
) (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic [31:0]         pc_i,
    input  bp_pkg::bp_update_t  upd_i,
    input  logic                pht_taken_i,
    input  logic                enable_i,
    input  logic                flush_i,
    output bp_pkg::bp_predict_t pred_o
);

    import bp_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_BITS = 30 - IDX_BITS; // PC bits above the index

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [31:0]         target;
        logic                jump;
        logic                branch;
    } btb_entry_t;

    btb_entry_t                 entry_q [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] valid_q;

    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;
    btb_entry_t          rd_entry;
    logic                hit;
    logic                taken;

    logic [IDX_BITS-1:0] wr_idx;
    logic                is_jump;
    logic                is_branch;
    logic                install;
    btb_entry_t          wr_entry;

    // ----------------------------------------
    // Lookup on the fetch PC
    // ----------------------------------------
    assign rd_idx   = pc_i[IDX_BITS+1:2];
    assign rd_tag   = pc_i[31:IDX_BITS+2];
    assign rd_entry = entry_q[rd_idx];
    assign hit      = valid_q[rd_idx] && (rd_entry.tag == rd_tag);

    // Jumps always redirect, branches only when the PHT agrees
    assign taken = enable_i && hit &&
                   (rd_entry.jump || (rd_entry.branch && pht_taken_i));

    assign pred_o.taken  = taken;
    assign pred_o.target = taken ? rd_entry.target : 32'd0;

    // ----------------------------------------
    // Install from execute
    // ----------------------------------------
    assign wr_idx    = upd_i.pc[IDX_BITS+1:2];
    assign is_jump   = (upd_i.op == OP_JAL) || (upd_i.op == OP_JALR);
    assign is_branch = (upd_i.op == OP_BRANCH);

    // A flush in the same cycle throws the install away
    assign install = upd_i.valid && (is_jump || is_branch) && !flush_i;

    always_comb begin
        wr_entry.tag    = upd_i.pc[31:IDX_BITS+2];
        wr_entry.target = upd_i.target;
        wr_entry.jump   = is_jump;
        wr_entry.branch = is_branch; // Installed whatever the resolved direction
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else if (install) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload, qualified by valid_q
    always_ff @(posedge clk) begin
        if (install) begin
            entry_q[wr_idx] <= wr_entry;
        end
    end

    // The execute stage must resolve the opcode before it raises the strobe
    a_upd_op_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        upd_i.valid |-> !$isunknown(upd_i.op)
    );

endmodule

// File: hw/bp_gshare.sv
// Gshare direction predictor
module bp_gshare #(
    parameter int NUM_GHR_BITS = 5
) (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  logic [31:0]             pc_i,
    input  bp_pkg::bp_update_t      upd_i,
    input  logic [NUM_GHR_BITS-1:0] upd_pht_index_i,
    input  logic                    flush_i,
    output logic                    pht_taken_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o
);

    import bp_pkg::*;

    localparam int PHT_ENTRIES = 1 << NUM_GHR_BITS;

    logic [NUM_GHR_BITS-1:0]     ghr_q;
    logic [PHT_ENTRIES-1:0][1:0] pht_q;
    logic                        branch_upd;
    logic [1:0]                  cnt_cur;
    logic [1:0]                  cnt_nxt;

    // ----------------------------------------
    // Read side
    // ----------------------------------------
    assign pht_index_o = pc_i[NUM_GHR_BITS+1:2] ^ ghr_q;
    assign pht_taken_o = pht_q[pht_index_o][1]; // Counter MSB is the direction

    // ----------------------------------------
    // Update side
    // ----------------------------------------
    assign branch_upd = upd_i.valid && (upd_i.op == OP_BRANCH) && !flush_i;

    // The pipeline hands back the index used at fetch, so the GHR at
    // resolution time does not matter here
    assign cnt_cur = pht_q[upd_pht_index_i];

    always_comb begin
        cnt_nxt = cnt_cur;
        if (upd_i.taken) begin
            if (cnt_cur != 2'b11) begin
                cnt_nxt = cnt_cur + 2'd1;
            end
        end else if (cnt_cur != 2'b00) begin
            cnt_nxt = cnt_cur - 2'd1;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ghr_q <= '0;
        end else if (flush_i) begin
            ghr_q <= '0;
        end else if (branch_upd) begin
            ghr_q <= {ghr_q[NUM_GHR_BITS-2:0], upd_i.taken}; // Newest outcome in the LSB
        end
    end

    // Counters are trained state and survive a flush
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pht_q <= {PHT_ENTRIES{PHT_INIT}};
        end else if (branch_upd) begin
            pht_q[upd_pht_index_i] <= cnt_nxt;
        end
    end

    // Only a resolved conditional branch may train the table
    a_pht_branch_only: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !(upd_i.valid && (upd_i.op == OP_BRANCH)) |=> $stable(pht_q)
    );

    a_index_known: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        !$isunknown(pht_index_o)
    );

endmodule

// File: hw/bp_csr.sv
// Predictor control and statistics
module bp_csr (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               cfg_we_i,
    input  logic [1:0]         cfg_addr_i,
    input  logic [31:0]        cfg_wdata_i,
    output logic [31:0]        cfg_rdata_o,
    input  bp_pkg::bp_update_t upd_i,
    output logic               enable_o,
    output logic               flush_o
);

    import bp_pkg::*;

    logic                  enable_q;
    logic                  flush_q;
    logic [STAT_WIDTH-1:0] branches_q;
    logic [STAT_WIDTH-1:0] misses_q;
    logic                  ctrl_we;
    logic                  branches_we;
    logic                  misses_we;
    logic                  branch_upd;
    logic                  mispredict;

    assign ctrl_we     = cfg_we_i && (cfg_addr_i == REG_CTRL);
    assign branches_we = cfg_we_i && (cfg_addr_i == REG_BRANCHES);
    assign misses_we   = cfg_we_i && (cfg_addr_i == REG_MISSES);

    // Counts every resolved branch, even one whose training a flush drops
    assign branch_upd = upd_i.valid && (upd_i.op == OP_BRANCH);
    assign mispredict = branch_upd && (upd_i.taken != upd_i.pred_taken);

    // ----------------------------------------
    // Control register
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= 1'b1;
            flush_q  <= 1'b0;
        end else begin
            if (ctrl_we) begin
                enable_q <= cfg_wdata_i[0];
            end
            // Self-clearing pulse in the cycle after the write
            flush_q <= ctrl_we && cfg_wdata_i[1];
        end
    end

    assign enable_o = enable_q;
    assign flush_o  = flush_q;

    // ----------------------------------------
    // Statistics
    // ----------------------------------------
    // A register write wins over counting
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            branches_q <= '0;
            misses_q   <= '0;
        end else begin
            if (branches_we) begin
                branches_q <= cfg_wdata_i[STAT_WIDTH-1:0];
            end else if (branch_upd) begin
                branches_q <= branches_q + 1'b1; // Wraps
            end
            if (misses_we) begin
                misses_q <= cfg_wdata_i[STAT_WIDTH-1:0];
            end else if (mispredict) begin
                misses_q <= misses_q + 1'b1;
            end
        end
    end

    always_comb begin
        case (cfg_addr_i)
            REG_CTRL:     cfg_rdata_o = {30'd0, flush_q, enable_q};
            REG_BRANCHES: cfg_rdata_o = {{(32-STAT_WIDTH){1'b0}}, branches_q};
            REG_MISSES:   cfg_rdata_o = {{(32-STAT_WIDTH){1'b0}}, misses_q};
            default:      cfg_rdata_o = 32'd0;
        endcase
    end

    a_flush_single: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        flush_o |=> !flush_o
    );

endmodule

// File: hw/bp_top.sv
// Fetch-side branch predictor
module bp_top #(
    parameter int NUM_BTB_ENTRIES = 32,
    parameter int NUM_GHR_BITS    = 5
) (
    input  logic                    clk,
    input  logic                    arst_n_i,

    // Fetch
    input  logic [31:0]             pc_i,
    output bp_pkg::bp_predict_t     pred_o,
    output logic [NUM_GHR_BITS-1:0] pht_index_o,

    // Execute resolution
    input  bp_pkg::bp_update_t      upd_i,
    input  logic [NUM_GHR_BITS-1:0] upd_pht_index_i,

    // Register access
    input  logic                    cfg_we_i,
    input  logic [1:0]              cfg_addr_i,
    input  logic [31:0]             cfg_wdata_i,
    output logic [31:0]             cfg_rdata_o
);

    logic enable;
    logic flush;    // One-cycle pulse
    logic pht_taken;

    // ----------------------------------------
    // Predictor blocks
    // ----------------------------------------
    bp_btb #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES)
    ) u_btb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .pc_i        (pc_i),
        .upd_i       (upd_i),
        .pht_taken_i (pht_taken),
        .enable_i    (enable),
        .flush_i     (flush),
        .pred_o      (pred_o)
    );

    bp_gshare #(
        .NUM_GHR_BITS (NUM_GHR_BITS)
    ) u_gshare (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .pc_i            (pc_i),
        .upd_i           (upd_i),
        .upd_pht_index_i (upd_pht_index_i),
        .flush_i         (flush),
        .pht_taken_o     (pht_taken),
        .pht_index_o     (pht_index_o)
    );

    // Configuration and statistics
    bp_csr u_csr (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .cfg_we_i    (cfg_we_i),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_wdata_i (cfg_wdata_i),
        .cfg_rdata_o (cfg_rdata_o),
        .upd_i       (upd_i),
        .enable_o    (enable),
        .flush_o     (flush)
    );

endmodule

// File: verification/bp_top_tb.sv
// Branch predictor testbench
module bp_top_tb;

    import bp_pkg::*;

    localparam int NUM_BTB_ENTRIES = 32;
    localparam int NUM_GHR_BITS    = 5;
    localparam int IDX_BITS        = $clog2(NUM_BTB_ENTRIES);
    localparam int TAG_BITS        = 30 - IDX_BITS;
    localparam int PHT_ENTRIES     = 1 << NUM_GHR_BITS;
    localparam int WAIT_LIMIT      = 20;
    localparam logic [6:0] OP_ALU  = 7'b0110011; // R-type, ignored by the predictor

    logic                    clk;
    logic                    arst_n_i;
    logic [31:0]             pc_i;
    bp_update_t              upd_i;
    logic [NUM_GHR_BITS-1:0] upd_pht_index_i;
    logic                    cfg_we_i;
    logic [1:0]              cfg_addr_i;
    logic [31:0]             cfg_wdata_i;
    bp_predict_t             pred_o;
    logic [NUM_GHR_BITS-1:0] pht_index_o;
    logic [31:0]             cfg_rdata_o;

    // Reference model state
    logic [NUM_BTB_ENTRIES-1:0] m_valid;
    logic [TAG_BITS-1:0]        m_tag [NUM_BTB_ENTRIES];
    logic [31:0]                m_target [NUM_BTB_ENTRIES];
    logic [NUM_BTB_ENTRIES-1:0] m_jump;
    logic [NUM_BTB_ENTRIES-1:0] m_branch;
    logic [NUM_GHR_BITS-1:0]    m_ghr;
    logic [1:0]                 m_pht [PHT_ENTRIES];
    logic                       m_enable;
    logic                       m_flush;
    logic [STAT_WIDTH-1:0]      m_branches;
    logic [STAT_WIDTH-1:0]      m_misses;

    logic [IDX_BITS-1:0]     exp_idx;
    logic [NUM_GHR_BITS-1:0] exp_pht_index;
    logic                    exp_hit;
    bp_predict_t             exp_pred;
    logic [31:0]             exp_rdata;
    logic [IDX_BITS-1:0]     upd_idx;

    int          pred_errors;
    int          index_errors;
    int          rdata_errors;
    int          timeout_errors;
    logic [31:0] pc_pool [8];

    bp_top #(
        .NUM_BTB_ENTRIES (NUM_BTB_ENTRIES),
        .NUM_GHR_BITS    (NUM_GHR_BITS)
    ) DUT (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .pc_i            (pc_i),
        .pred_o          (pred_o),
        .pht_index_o     (pht_index_o),
        .upd_i           (upd_i),
        .upd_pht_index_i (upd_pht_index_i),
        .cfg_we_i        (cfg_we_i),
        .cfg_addr_i      (cfg_addr_i),
        .cfg_wdata_i     (cfg_wdata_i),
        .cfg_rdata_o     (cfg_rdata_o)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic logic [1:0] step_counter(input logic [1:0] cnt, input logic taken);
        if (taken) begin
            return (cnt == 2'd3) ? 2'd3 : cnt + 2'd1;
        end
        return (cnt == 2'd0) ? 2'd0 : cnt - 2'd1;
    endfunction

    assign upd_idx = upd_i.pc[IDX_BITS+1:2];

    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_valid    <= '0;
            m_jump     <= '0;
            m_branch   <= '0;
            m_ghr      <= '0;
            m_enable   <= 1'b1;
            m_flush    <= 1'b0;
            m_branches <= '0;
            m_misses   <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                m_pht[i] <= PHT_INIT;
            end
        end else begin
            m_flush <= cfg_we_i && (cfg_addr_i == REG_CTRL) && cfg_wdata_i[1];
            if (cfg_we_i && (cfg_addr_i == REG_CTRL)) begin
                m_enable <= cfg_wdata_i[0];
            end
            if (m_flush) begin // Pulse wins over a same-cycle update
                m_valid <= '0;
                m_ghr   <= '0;
            end else if (upd_i.valid) begin
                if (upd_i.op inside {OP_JAL, OP_JALR, OP_BRANCH}) begin
                    m_valid[upd_idx]  <= 1'b1;
                    m_tag[upd_idx]    <= upd_i.pc[31:IDX_BITS+2];
                    m_target[upd_idx] <= upd_i.target;
                    m_jump[upd_idx]   <= (upd_i.op != OP_BRANCH);
                    m_branch[upd_idx] <= (upd_i.op == OP_BRANCH);
                end
                if (upd_i.op == OP_BRANCH) begin
                    m_pht[upd_pht_index_i] <= step_counter(m_pht[upd_pht_index_i], upd_i.taken);
                    m_ghr <= {m_ghr[NUM_GHR_BITS-2:0], upd_i.taken};
                end
            end
            if (cfg_we_i && (cfg_addr_i == REG_BRANCHES)) begin
                m_branches <= cfg_wdata_i[STAT_WIDTH-1:0];
            end else if (upd_i.valid && (upd_i.op == OP_BRANCH)) begin
                m_branches <= m_branches + STAT_WIDTH'(1);
            end
            if (cfg_we_i && (cfg_addr_i == REG_MISSES)) begin
                m_misses <= cfg_wdata_i[STAT_WIDTH-1:0];
            end else if (upd_i.valid && (upd_i.op == OP_BRANCH) &&
                         (upd_i.taken != upd_i.pred_taken)) begin
                m_misses <= m_misses + STAT_WIDTH'(1);
            end
        end
    end

    always_comb begin
        exp_idx         = pc_i[IDX_BITS+1:2];
        exp_hit         = m_valid[exp_idx] && (m_tag[exp_idx] == pc_i[31:IDX_BITS+2]);
        exp_pht_index   = pc_i[NUM_GHR_BITS+1:2] ^ m_ghr;
        exp_pred.taken  = m_enable && exp_hit &&
                          (m_jump[exp_idx] || (m_branch[exp_idx] && m_pht[exp_pht_index][1]));
        exp_pred.target = exp_pred.taken ? m_target[exp_idx] : 32'd0;
        case (cfg_addr_i)
            REG_CTRL:     exp_rdata = {30'd0, m_flush, m_enable};
            REG_BRANCHES: exp_rdata = {{(32-STAT_WIDTH){1'b0}}, m_branches};
            REG_MISSES:   exp_rdata = {{(32-STAT_WIDTH){1'b0}}, m_misses};
            default:      exp_rdata = 32'd0;
        endcase
    end

    // ----------------------------------------
    // Checks against the model
    // ----------------------------------------
    a_pred: assert property (@(posedge clk) disable iff (!arst_n_i) pred_o == exp_pred)
        else begin
            pred_errors = pred_errors + 1;
            $display("[FAIL] pred_o: got %h, expected %h", $sampled(pred_o), $sampled(exp_pred));
        end

    a_pht_index: assert property (@(posedge clk) disable iff (!arst_n_i)
                                  pht_index_o == exp_pht_index)
        else begin
            index_errors = index_errors + 1;
            $display("[FAIL] pht_index_o: got %h, expected %h",
                     $sampled(pht_index_o), $sampled(exp_pht_index));
        end

    a_rdata: assert property (@(posedge clk) disable iff (!arst_n_i) cfg_rdata_o == exp_rdata)
        else begin
            rdata_errors = rdata_errors + 1;
            $display("[FAIL] cfg_rdata_o: got %h, expected %h",
                     $sampled(cfg_rdata_o), $sampled(exp_rdata));
        end

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    function automatic logic [31:0] rand_pc();
        return $urandom() & 32'hffff_fffc;
    endfunction

    task automatic clear_strobes();
        upd_i.valid = 1'b0;
        cfg_we_i    = 1'b0;
    endtask

    task automatic fetch(input logic [31:0] pc);
        @(negedge clk);
        clear_strobes();
        pc_i = pc;
    endtask

    task automatic send_update(input logic [31:0] pc, input logic [31:0] target,
                               input logic [6:0] op, input logic taken,
                               input logic pred_taken);
        @(negedge clk);
        clear_strobes();
        upd_i.valid      = 1'b1;
        upd_i.pc         = pc;
        upd_i.target     = target;
        upd_i.op         = op;
        upd_i.taken      = taken;
        upd_i.pred_taken = pred_taken;
        upd_pht_index_i  = pc[NUM_GHR_BITS+1:2] ^ m_ghr; // Index fetch would have used
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        @(negedge clk);
        clear_strobes();
        cfg_we_i    = 1'b1;
        cfg_addr_i  = addr;
        cfg_wdata_i = data;
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            clear_strobes();
            cfg_addr_i = 2'(i);
        end
    endtask

    task automatic random_step();
        int          pick;
        logic [31:0] pc;
        pick = $urandom % 10;
        pc   = pc_pool[$urandom % 8];
        if (pick < 5) begin
            send_update(pc, rand_pc(), OP_BRANCH, 1'($urandom), 1'($urandom));
        end else if (pick == 5) begin
            send_update(pc, rand_pc(), OP_JAL, 1'b1, 1'b1);
        end else if (pick == 6) begin
            send_update(pc, rand_pc(), OP_ALU, 1'($urandom), 1'b0);
        end else begin
            fetch(pc);
        end
    endtask

    task automatic wait_enabled();
        int cycles;
        cycles     = 0;
        cfg_addr_i = REG_CTRL;
        do begin
            @(negedge clk);
            cycles++;
        end while ((cfg_rdata_o[0] !== 1'b1) && (cycles < WAIT_LIMIT));
        if (cfg_rdata_o[0] !== 1'b1) begin
            timeout_errors++;
            $display("Timeout: predictor never read back as enabled after reset");
        end
    endtask

    // Flush bit shows for one cycle in REG_CTRL
    task automatic wait_flush_done();
        int   cycles;
        logic seen;
        logic done;
        cycles = 0;
        seen   = 1'b0;
        done   = 1'b0;
        while (!done && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            clear_strobes();
            cycles++;
            if (cfg_rdata_o[1]) begin
                seen = 1'b1;
            end else if (seen) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            timeout_errors++;
            $display("Timeout: flush pulse did not appear and clear in REG_CTRL");
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] jump_pc;
        int          shift;
        void'($urandom(32'hd682_c41a));
        pred_errors     = 0;
        index_errors    = 0;
        rdata_errors    = 0;
        timeout_errors  = 0;
        arst_n_i        = 1'b0;
        pc_i            = '0;
        upd_i           = '0;
        upd_pht_index_i = '0;
        cfg_we_i        = 1'b0;
        cfg_addr_i      = REG_CTRL;
        cfg_wdata_i     = '0;
        for (int i = 0; i < 8; i++) begin
            pc_pool[i] = rand_pc();
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        wait_enabled();

        repeat (20) fetch(rand_pc()); // Nothing installed yet
        read_all_regs();

        // Jump installs, tag aliases and overwrites
        repeat (8) begin
            jump_pc = rand_pc();
            shift   = IDX_BITS + 2 + ($urandom % TAG_BITS);
            send_update(jump_pc, rand_pc(), ($urandom % 2) ? OP_JAL : OP_JALR, 1'b1, 1'b0);
            fetch(jump_pc);
            fetch(jump_pc ^ (32'h1 << shift));
            send_update(jump_pc, rand_pc(), OP_JALR, 1'b1, 1'b1);
            fetch(jump_pc);
        end

        // Branch training over a small set of PCs
        for (int i = 0; i < 8; i++) begin
            send_update(pc_pool[i], rand_pc(), OP_BRANCH, 1'($urandom), 1'($urandom));
        end
        repeat (200) random_step();
        repeat (10) begin
            send_update(pc_pool[0], rand_pc(), OP_BRANCH, 1'b1, 1'b1);
            fetch(pc_pool[0]);
        end
        repeat (10) begin
            send_update(pc_pool[0], rand_pc(), OP_BRANCH, 1'b0, 1'b1);
            fetch(pc_pool[0]);
        end

        // Predictions off while training continues
        cfg_write(REG_CTRL, 32'h0);
        repeat (40) random_step();
        cfg_write(REG_CTRL, 32'h1);
        for (int i = 0; i < 8; i++) begin
            fetch(pc_pool[i]);
        end

        cfg_write(REG_CTRL, 32'h3);
        wait_flush_done();
        for (int i = 0; i < 8; i++) begin
            fetch(pc_pool[i]);
        end
        repeat (30) random_step();
        // Updates that land on the flush pulse
        cfg_write(REG_CTRL, 32'h3);
        send_update(pc_pool[2], rand_pc(), OP_BRANCH, 1'b1, 1'b0);
        fetch(pc_pool[2]);
        cfg_write(REG_CTRL, 32'h3);
        send_update(pc_pool[3], rand_pc(), OP_JAL, 1'b1, 1'b1);
        fetch(pc_pool[3]);

        // Statistics writes and wrap
        read_all_regs();
        cfg_write(REG_BRANCHES, {16'($urandom), 16'hfffd});
        cfg_write(REG_MISSES, $urandom);
        repeat (6) send_update(rand_pc(), rand_pc(), OP_BRANCH, 1'($urandom), 1'($urandom));
        read_all_regs();
        cfg_write(REG_MISSES, 32'h0000_fffe);
        repeat (4) send_update(rand_pc(), rand_pc(), OP_BRANCH, 1'b1, 1'b0);
        repeat (20) random_step();
        read_all_regs();

        @(negedge clk);
        clear_strobes();
        repeat (2) @(negedge clk);
        $display("Errors: pred_o %0d, pht_index_o %0d, cfg_rdata_o %0d, timeouts %0d",
                 pred_errors, index_errors, rdata_errors, timeout_errors);
        if ((pred_errors + index_errors + rdata_errors + timeout_errors) == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: branch_predictor.f
hw/bp_pkg.sv
hw/bp_btb.sv
hw/bp_gshare.sv
hw/bp_csr.sv
hw/bp_top.sv
verification/bp_top_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = bp_top_tb
FILELIST  = branch_predictor.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
